/* verilog/rvIsaPkg.sv */
package rvIsaPkg;

	localparam int XLEN = 32;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] OpReg    = 7'b0110011;
	localparam logic [6:0] OpImm    = 7'b0010011;
	localparam logic [6:0] OpLui    = 7'b0110111;
	localparam logic [6:0] OpAuipc  = 7'b0010111;
	localparam logic [6:0] OpLoad   = 7'b0000011;
	localparam logic [6:0] OpStore  = 7'b0100011;
	localparam logic [6:0] OpJal    = 7'b1101111;
	localparam logic [6:0] OpJalr   = 7'b1100111;
	localparam logic [6:0] OpBranch = 7'b1100011;

	localparam logic [XLEN-1:0] ResetPc = 32'h0;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluSlt,
		AluSltu,
		AluSll,
		AluSrl,
		AluSra,
		AluPassB,
		AluPcAdd
	} aluOpE;

	typedef enum logic [2:0] {
		BrNone,
		BrEq,
		BrNe,
		BrLt,
		BrGe,
		BrLtu,
		BrGeu
	} brCondE;

	typedef enum logic [1:0] {
		WbAlu,
		WbMem,
		WbPc4
	} wbSelE;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		wbSelE wbSel;
		logic aluSrcImm;
		logic aluSrcPc;
		aluOpE aluOp;
		brCondE brCond;
		logic isJal;
		logic isJalr;
		logic illegal;
	} ctrlWordT;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0] instr;
		logic [4:0] rd;
		logic [XLEN-1:0] rdValue;
		logic rdWrite;
	} retireT;

endpackage

/* verilog/rvBusPkg.sv */
package rvBusPkg;

	// Wait cycles allowed per access before the core gives up
	localparam int BusTimeoutCycles = 16;
	localparam int TimerWidth = 5;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [31:0] prdata;
	} apbRspT;

endpackage

/* verilog/controlDecoder.sv */
module controlDecoder (
	input logic [31:0] instr,
	output rvIsaPkg::ctrlWordT ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic isShift;
	logic altOk;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign isShift = funct3 == 3'b001 || funct3 == 3'b101;
	// Only ADD/SUB and SRL/SRA have an alternate form
	assign altOk = funct3 == 3'b000 || funct3 == 3'b101;

	function automatic rvIsaPkg::aluOpE aluOpFor(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rvIsaPkg::AluSub : rvIsaPkg::AluAdd;
			3'b001: return rvIsaPkg::AluSll;
			3'b010: return rvIsaPkg::AluSlt;
			3'b011: return rvIsaPkg::AluSltu;
			3'b100: return rvIsaPkg::AluXor;
			3'b101: return alt ? rvIsaPkg::AluSra : rvIsaPkg::AluSrl;
			3'b110: return rvIsaPkg::AluOr;
			default: return rvIsaPkg::AluAnd;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.illegal = 1'b1;
		case (opcode)
			rvIsaPkg::OpReg: begin
				if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && altOk)) begin
					ctrl.illegal = 1'b0;
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = aluOpFor(funct3, funct7[5]);
				end
			end
			rvIsaPkg::OpImm: begin
				if (!isShift || funct7 == 7'b0000000
						|| (funct7 == 7'b0100000 && funct3 == 3'b101)) begin
					ctrl.illegal = 1'b0;
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					// ADDI never becomes a subtract
					ctrl.aluOp = aluOpFor(funct3, isShift && funct7[5]);
				end
			end
			rvIsaPkg::OpLui: begin
				ctrl.illegal = 1'b0;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = rvIsaPkg::AluPassB;
			end
			rvIsaPkg::OpAuipc: begin
				ctrl.illegal = 1'b0;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluOp = rvIsaPkg::AluPcAdd;
			end
			rvIsaPkg::OpLoad: begin
				if (funct3 == 3'b010) begin
					ctrl.illegal = 1'b0;
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.wbSel = rvIsaPkg::WbMem;
					ctrl.aluSrcImm = 1'b1;
				end
			end
			rvIsaPkg::OpStore: begin
				if (funct3 == 3'b010) begin
					ctrl.illegal = 1'b0;
					ctrl.memWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
				end
			end
			rvIsaPkg::OpJal: begin
				ctrl.illegal = 1'b0;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvIsaPkg::WbPc4;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluOp = rvIsaPkg::AluPcAdd;
				ctrl.isJal = 1'b1;
			end
			rvIsaPkg::OpJalr: begin
				if (funct3 == 3'b000) begin
					ctrl.illegal = 1'b0;
					ctrl.regWrite = 1'b1;
					ctrl.wbSel = rvIsaPkg::WbPc4;
					ctrl.aluSrcImm = 1'b1;
					ctrl.isJalr = 1'b1;
				end
			end
			rvIsaPkg::OpBranch: begin
				ctrl.illegal = 1'b0;
				case (funct3)
					3'b000: ctrl.brCond = rvIsaPkg::BrEq;
					3'b001: ctrl.brCond = rvIsaPkg::BrNe;
					3'b100: ctrl.brCond = rvIsaPkg::BrLt;
					3'b101: ctrl.brCond = rvIsaPkg::BrGe;
					3'b110: ctrl.brCond = rvIsaPkg::BrLtu;
					3'b111: ctrl.brCond = rvIsaPkg::BrGeu;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* verilog/aluUnit.sv */
module aluUnit (
	input logic [31:0] opA,
	input logic [31:0] opB,
	input rvIsaPkg::aluOpE aluOp,
	input rvIsaPkg::brCondE brCond,
	output logic [31:0] result,
	output logic brTaken
);

	logic [4:0] shamt;
	logic ltSigned;
	logic ltUnsigned;
	logic equal;

	assign shamt = opB[4:0];
	assign ltSigned = $signed(opA) < $signed(opB);
	assign ltUnsigned = opA < opB;
	assign equal = opA == opB;

	always_comb begin
		case (aluOp)
			rvIsaPkg::AluAdd,
			rvIsaPkg::AluPcAdd: result = opA + opB;
			rvIsaPkg::AluSub: result = opA - opB;
			rvIsaPkg::AluAnd: result = opA & opB;
			rvIsaPkg::AluOr: result = opA | opB;
			rvIsaPkg::AluXor: result = opA ^ opB;
			rvIsaPkg::AluSlt: result = {31'b0, ltSigned};
			rvIsaPkg::AluSltu: result = {31'b0, ltUnsigned};
			rvIsaPkg::AluSll: result = opA << shamt;
			rvIsaPkg::AluSrl: result = opA >> shamt;
			rvIsaPkg::AluSra: result = $unsigned($signed(opA) >>> shamt);
			rvIsaPkg::AluPassB: result = opB;
			default: result = '0;
		endcase
	end

	// Branch compare runs on the same operands
	always_comb begin
		case (brCond)
			rvIsaPkg::BrEq: brTaken = equal;
			rvIsaPkg::BrNe: brTaken = !equal;
			rvIsaPkg::BrLt: brTaken = ltSigned;
			rvIsaPkg::BrGe: brTaken = !ltSigned;
			rvIsaPkg::BrLtu: brTaken = ltUnsigned;
			rvIsaPkg::BrGeu: brTaken = !ltUnsigned;
			default: brTaken = 1'b0;
		endcase
	end

endmodule

/* verilog/regFile.sv */
module regFile (
	input logic clk,
	input logic rstN,
	input logic [4:0] rs1Addr,
	input logic [4:0] rs2Addr,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data,
	input logic wrEn,
	input logic [4:0] wrAddr,
	input logic [31:0] wrData
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// x0 is never written, so it reads back zero
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

endmodule

/* verilog/coreSequencer.sv */
module coreSequencer (
	input logic clk,
	input logic rstN,
	output logic [31:0] instr,
	input rvIsaPkg::ctrlWordT ctrl,
	output logic [4:0] rs1Addr,
	output logic [4:0] rs2Addr,
	input logic [31:0] rs1Data,
	input logic [31:0] rs2Data,
	output logic [31:0] opA,
	output logic [31:0] opB,
	output rvIsaPkg::aluOpE aluOp,
	output rvIsaPkg::brCondE brCond,
	input logic [31:0] result,
	input logic brTaken,
	output logic wrEn,
	output logic [4:0] wrAddr,
	output logic [31:0] wrData,
	output rvBusPkg::apbReqT apbReq,
	input rvBusPkg::apbRspT apbRsp,
	output logic apbAccess,
	input logic timeout,
	output logic retireValid,
	output rvIsaPkg::retireT retire,
	output logic halted,
	output logic busError
);

	typedef enum logic [2:0] {
		FetchSetup,
		FetchAccess,
		Decode,
		Execute,
		MemSetup,
		MemAccess,
		WriteBack,
		Halt
	} stateE;

	stateE state;
	stateE stateNext;
	logic [rvIsaPkg::XLEN-1:0] pc;
	logic [rvIsaPkg::XLEN-1:0] pcNext;
	logic [rvIsaPkg::XLEN-1:0] nextPc;
	logic [rvIsaPkg::XLEN-1:0] pcPlus4;
	logic [31:0] instrReg;
	logic [31:0] immNext;
	logic [31:0] immReg;
	logic [31:0] rs1Reg;
	logic [31:0] rs2Reg;
	logic [31:0] resultReg;
	logic [31:0] loadReg;
	logic [31:0] wbData;
	logic memPhase;
	logic accessPhase;
	logic busFail;

	assign instr = instrReg;
	assign rs1Addr = instrReg[19:15];
	assign rs2Addr = instrReg[24:20];
	assign pcPlus4 = pc + 32'd4;
	assign memPhase = state == MemSetup || state == MemAccess;
	assign accessPhase = state == FetchAccess || state == MemAccess;
	assign busFail = accessPhase && (timeout || (apbRsp.pready && apbRsp.pslverr));

	always_comb begin
		case (instrReg[6:0])
			rvIsaPkg::OpStore: immNext = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
			rvIsaPkg::OpBranch: immNext = {{19{instrReg[31]}}, instrReg[31], instrReg[7],
				instrReg[30:25], instrReg[11:8], 1'b0};
			rvIsaPkg::OpLui,
			rvIsaPkg::OpAuipc: immNext = {instrReg[31:12], 12'b0};
			rvIsaPkg::OpJal: immNext = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12],
				instrReg[20], instrReg[30:21], 1'b0};
			default: immNext = {{20{instrReg[31]}}, instrReg[31:20]};
		endcase
	end

	assign opA = ctrl.aluSrcPc ? pc : rs1Reg;
	assign opB = ctrl.aluSrcImm ? immReg : rs2Reg;
	assign aluOp = ctrl.aluOp;
	assign brCond = ctrl.brCond;

	always_comb begin
		if (ctrl.isJalr) begin
			pcNext = {result[31:1], 1'b0};
		end else if (ctrl.isJal) begin
			pcNext = result;
		end else if (brTaken) begin
			pcNext = pc + immReg;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			FetchSetup: stateNext = FetchAccess;
			FetchAccess: begin
				if (busFail) stateNext = Halt;
				else if (apbRsp.pready) stateNext = Decode;
			end
			Decode: stateNext = ctrl.illegal ? Halt : Execute;
			Execute: stateNext = (ctrl.memRead || ctrl.memWrite) ? MemSetup : WriteBack;
			MemSetup: stateNext = MemAccess;
			MemAccess: begin
				if (busFail) stateNext = Halt;
				else if (apbRsp.pready) stateNext = WriteBack;
			end
			WriteBack: stateNext = FetchSetup;
			// Out of reset the core idles here one edge before the first fetch
			Halt: if (!halted) stateNext = FetchSetup;
			default: stateNext = Halt;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= Halt;
			pc <= rvIsaPkg::ResetPc;
			halted <= 1'b0;
			busError <= 1'b0;
		end else begin
			state <= stateNext;
			if (state == WriteBack) pc <= nextPc;
			if (state == Decode && ctrl.illegal) halted <= 1'b1;
			if (busFail) begin
				halted <= 1'b1;
				busError <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == FetchAccess && apbRsp.pready) instrReg <= apbRsp.prdata;
		if (state == Decode) begin
			rs1Reg <= rs1Data;
			rs2Reg <= rs2Data;
			immReg <= immNext;
		end
		if (state == Execute) begin
			resultReg <= result;
			nextPc <= pcNext;
		end
		if (state == MemAccess && apbRsp.pready) loadReg <= apbRsp.prdata;
	end

	// APB master, address and data held steady by the state registers
	assign apbReq.psel = state == FetchSetup || state == FetchAccess || memPhase;
	assign apbReq.penable = accessPhase;
	assign apbReq.pwrite = memPhase && ctrl.memWrite;
	assign apbReq.paddr = memPhase ? resultReg : pc;
	assign apbReq.pwdata = rs2Reg;
	assign apbAccess = accessPhase;

	always_comb begin
		case (ctrl.wbSel)
			rvIsaPkg::WbMem: wbData = loadReg;
			rvIsaPkg::WbPc4: wbData = pcPlus4;
			default: wbData = resultReg;
		endcase
	end

	assign wrEn = state == WriteBack && ctrl.regWrite;
	assign wrAddr = instrReg[11:7];
	assign wrData = wbData;

	assign retireValid = state == WriteBack;
	assign retire.pc = pc;
	assign retire.instr = instrReg;
	assign retire.rd = ctrl.regWrite ? instrReg[11:7] : 5'd0;
	assign retire.rdValue = (ctrl.regWrite && instrReg[11:7] != 5'd0) ? wbData : '0;
	assign retire.rdWrite = ctrl.regWrite;

endmodule

/* verilog/busWaitTimer.sv */
module busWaitTimer (
	input logic clk,
	input logic rstN,
	input logic apbAccess,
	input logic pready,
	output logic timeout
);

	logic [rvBusPkg::TimerWidth-1:0] count;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (!apbAccess || pready) begin
			count <= '0;
		end else if (!timeout) begin
			count <= count + 1'b1;
		end
	end

	// Fires in the cycle the limit is reached, still without pready
	assign timeout = apbAccess && !pready
		&& count == rvBusPkg::TimerWidth'(rvBusPkg::BusTimeoutCycles);

endmodule

/* verilog/rvCore.sv */
module rvCore (
	input logic clk,
	input logic rstN,
	output rvBusPkg::apbReqT apbReq,
	input rvBusPkg::apbRspT apbRsp,
	output logic retireValid,
	output rvIsaPkg::retireT retire,
	output logic halted,
	output logic busError
);

	logic [31:0] instr;
	rvIsaPkg::ctrlWordT ctrl;
	logic [4:0] rs1Addr;
	logic [4:0] rs2Addr;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] opA;
	logic [31:0] opB;
	rvIsaPkg::aluOpE aluOp;
	rvIsaPkg::brCondE brCond;
	logic [31:0] result;
	logic brTaken;
	logic wrEn;
	logic [4:0] wrAddr;
	logic [31:0] wrData;
	logic apbAccess;
	logic timeout;

	coreSequencer sequencer (
		.clk(clk), .rstN(rstN), .instr(instr), .ctrl(ctrl),
		.rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.opA(opA), .opB(opB), .aluOp(aluOp), .brCond(brCond),
		.result(result), .brTaken(brTaken),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.apbReq(apbReq), .apbRsp(apbRsp), .apbAccess(apbAccess), .timeout(timeout),
		.retireValid(retireValid), .retire(retire), .halted(halted), .busError(busError)
	);

	controlDecoder decoder (.instr(instr), .ctrl(ctrl));

	aluUnit alu (
		.opA(opA), .opB(opB), .aluOp(aluOp), .brCond(brCond),
		.result(result), .brTaken(brTaken)
	);

	regFile regs (
		.clk(clk), .rstN(rstN), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
	);

	busWaitTimer waitTimer (
		.clk(clk), .rstN(rstN), .apbAccess(apbAccess), .pready(apbRsp.pready),
		.timeout(timeout)
	);

endmodule

/* dv/rvCoreApb_checker.sv */
module rvCoreApb_checker (
	input logic clk,
	input logic rstN,
	input rvBusPkg::apbReqT apbReq,
	input rvBusPkg::apbRspT apbRsp,
	input logic halted
);

	logic pending;
	int failCount = 0;

	// Transfer open and not completing on this edge
	assign pending = apbReq.psel && !(apbReq.penable && apbRsp.pready);

	assert property (@(posedge clk) disable iff (!rstN)
		pending ##1 apbReq.psel |-> $stable(apbReq.paddr) && $stable(apbReq.pwrite)
			&& $stable(apbReq.pwdata))
		else begin
			$error("APB address, direction or write data changed before completion");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rstN)
		apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable)
		else begin
			$error("APB setup cycle not followed by an access phase");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rstN)
		$rose(apbReq.penable) |-> $past(apbReq.psel && !apbReq.penable))
		else begin
			$error("APB penable rose without a preceding setup cycle");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !apbReq.psel)
		else begin
			$error("APB psel active while the core is halted");
			failCount++;
		end

endmodule

/* dv/rvCoreMonitor.sv */
module rvCoreMonitor (
	input logic clk,
	input logic rstN,
	input logic retireValid,
	input rvIsaPkg::retireT retire,
	input logic halted,
	input logic busError,
	input logic statusCheck,
	input logic expHalted,
	input logic expBusError,
	input logic [31:0] expHaltPc,
	output int retireCount,
	output int statusCount,
	output int errorCount
);

	logic [31:0] modelMem [1024];
	logic [31:0] modelRegs [32];
	logic [31:0] modelPc;
	logic needReset;
	rvIsaPkg::retireT expected;

	initial begin
		retireCount = 0;
		statusCount = 0;
		errorCount = 0;
		needReset = 1'b1;
	end

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// ISA model stepping one instruction per call
	function automatic rvIsaPkg::retireT stepModel();
		rvIsaPkg::retireT exp;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] addr;
		logic [31:0] val;
		logic [31:0] nextPc;
		logic [4:0] rd;
		logic wr;
		ins = modelMem[modelPc[11:2]];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		rd = ins[11:7];
		wr = 1'b1;
		val = '0;
		nextPc = modelPc + 32'd4;
		case (ins[6:0])
			rvIsaPkg::OpReg: val = aluRef(ins[14:12], ins[30], a, b);
			rvIsaPkg::OpImm: val = aluRef(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immI);
			rvIsaPkg::OpLui: val = {ins[31:12], 12'b0};
			rvIsaPkg::OpAuipc: val = modelPc + {ins[31:12], 12'b0};
			rvIsaPkg::OpLoad: begin
				addr = a + immI;
				val = modelMem[addr[11:2]];
			end
			rvIsaPkg::OpStore: begin
				wr = 1'b0;
				addr = a + immS;
				modelMem[addr[11:2]] = b;
			end
			rvIsaPkg::OpJal: begin
				val = modelPc + 32'd4;
				nextPc = modelPc + immJ;
			end
			rvIsaPkg::OpJalr: begin
				val = modelPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			rvIsaPkg::OpBranch: begin
				wr = 1'b0;
				if (branchRef(ins[14:12], a, b)) nextPc = modelPc + immB;
			end
			default: wr = 1'b0;
		endcase
		if (wr && rd != 5'd0) modelRegs[rd] = val;
		exp.pc = modelPc;
		exp.instr = ins;
		exp.rd = wr ? rd : 5'd0;
		exp.rdValue = (wr && rd != 5'd0) ? val : '0;
		exp.rdWrite = wr;
		modelPc = nextPc;
		return exp;
	endfunction

	task automatic resetModel();
		modelPc = rvIsaPkg::ResetPc;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		// Program image as loaded by the testbench
		for (int i = 0; i < 1024; i++) begin
			modelMem[i] = rvCoreTb.mem[i];
		end
	endtask

	task automatic compareField(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h at time %0t", name, got, exp, $time);
			errorCount++;
		end
	endtask

	always @(negedge clk) begin
		if (!rstN) begin
			needReset = 1'b1;
		end else begin
			if (needReset) resetModel();
			needReset = 1'b0;
			if (retireValid) begin
				if (halted) begin
					$display("A retire at pc 0x%h was reported after the core halted", retire.pc);
					errorCount++;
				end
				expected = stepModel();
				compareField("retire.pc", retire.pc, expected.pc);
				compareField("retire.instr", retire.instr, expected.instr);
				compareField("retire.rd", 32'(retire.rd), 32'(expected.rd));
				compareField("retire.rdValue", retire.rdValue, expected.rdValue);
				compareField("retire.rdWrite", 32'(retire.rdWrite), 32'(expected.rdWrite));
				retireCount++;
			end
			if (statusCheck) begin
				statusCount++;
				compareField("halted", 32'(halted), 32'(expHalted));
				compareField("busError", 32'(busError), 32'(expBusError));
				// Model pc shows how far the program got
				compareField("haltPc", modelPc, expHaltPc);
			end
		end
	end

endmodule

/* dv/rvCoreTb.sv */
module rvCoreTb;

	logic clk;
	logic rstN;
	rvBusPkg::apbReqT apbReq;
	rvBusPkg::apbRspT apbRsp;
	logic retireValid;
	rvIsaPkg::retireT retire;
	logic halted;
	logic busError;

	logic [31:0] mem [1024];
	logic [31:0] progA [$];
	logic [31:0] progB [$];
	logic holdEnable;
	integer seed;
	int waitCount;
	int waitTarget;
	int cycleLimit;
	logic statusCheck;
	logic expHalted;
	logic expBusError;
	logic [31:0] expHaltPc;
	int retireCount;
	int statusCount;
	int errorCount;

	rvCore uut (
		.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp),
		.retireValid(retireValid), .retire(retire), .halted(halted), .busError(busError)
	);

	rvCoreMonitor monitor (
		.clk(clk), .rstN(rstN), .retireValid(retireValid), .retire(retire),
		.halted(halted), .busError(busError), .statusCheck(statusCheck),
		.expHalted(expHalted), .expBusError(expBusError), .expHaltPc(expHaltPc),
		.retireCount(retireCount), .statusCount(statusCount), .errorCount(errorCount)
	);

	bind rvCore rvCoreApb_checker apbChecker (
		.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp), .halted(halted)
	);

	function automatic logic [31:0] rType(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), rvIsaPkg::OpReg};
	endfunction

	function automatic logic [31:0] iType(input logic [6:0] op, input int f3, input int rd,
			input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
	endfunction

	function automatic logic [31:0] sType(input int rs1, input int rs2, input int imm);
		logic [11:0] s;
		s = 12'(imm);
		return {s[11:5], 5'(rs2), 5'(rs1), 3'd2, s[4:0], rvIsaPkg::OpStore};
	endfunction

	function automatic logic [31:0] bType(input int f3, input int rs1, input int rs2,
			input int imm);
		logic [12:0] b;
		b = 13'(imm);
		return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], rvIsaPkg::OpBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [6:0] op, input int rd, input int imm);
		return {20'(imm), 5'(rd), op};
	endfunction

	function automatic logic [31:0] jType(input int rd, input int imm);
		logic [20:0] j;
		j = 21'(imm);
		return {j[20], j[10:1], j[11], j[19:12], 5'(rd), rvIsaPkg::OpJal};
	endfunction

	task automatic buildPrograms();
		progA.push_back(uType(rvIsaPkg::OpLui, 1, 'h80000));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 2, 0, -1));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 3, 0, 5));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 4, 0, 31));
		progA.push_back(iType(rvIsaPkg::OpImm, 6, 5, 0, 'h7ff));
		progA.push_back(iType(rvIsaPkg::OpImm, 4, 6, 2, 'h123));
		progA.push_back(iType(rvIsaPkg::OpImm, 7, 7, 2, 'h0f0));
		progA.push_back(iType(rvIsaPkg::OpImm, 2, 8, 2, 1));
		progA.push_back(iType(rvIsaPkg::OpImm, 3, 9, 2, 1));
		progA.push_back(iType(rvIsaPkg::OpImm, 2, 10, 3, -4));
		progA.push_back(iType(rvIsaPkg::OpImm, 3, 11, 3, -4));
		// Immediate shifts by 31 and by 0
		progA.push_back(iType(rvIsaPkg::OpImm, 1, 12, 3, 31));
		progA.push_back(iType(rvIsaPkg::OpImm, 1, 13, 3, 0));
		progA.push_back(iType(rvIsaPkg::OpImm, 5, 14, 1, 31));
		progA.push_back(iType(rvIsaPkg::OpImm, 5, 15, 1, 0));
		progA.push_back(iType(rvIsaPkg::OpImm, 5, 16, 1, 'h41f));
		progA.push_back(iType(rvIsaPkg::OpImm, 5, 17, 1, 'h400));
		progA.push_back(rType(0, 0, 18, 1, 2));
		progA.push_back(rType('h20, 0, 19, 3, 4));
		progA.push_back(rType(0, 7, 20, 2, 5));
		progA.push_back(rType(0, 6, 21, 1, 3));
		progA.push_back(rType(0, 4, 22, 2, 3));
		progA.push_back(rType(0, 2, 23, 1, 3));
		progA.push_back(rType(0, 3, 24, 1, 3));
		progA.push_back(rType(0, 1, 25, 3, 4));
		progA.push_back(rType(0, 5, 26, 1, 4));
		progA.push_back(rType('h20, 5, 27, 1, 4));
		progA.push_back(rType('h20, 5, 28, 1, 0));
		progA.push_back(rType(0, 1, 29, 2, 0));
		progA.push_back(uType(rvIsaPkg::OpAuipc, 30, 'h12345));
		progA.push_back(uType(rvIsaPkg::OpLui, 31, 'habcde));
		// Store and load back through the data area at 0x200
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 5, 0, 'h200));
		progA.push_back(sType(5, 31, 0));
		progA.push_back(sType(5, 30, 4));
		progA.push_back(iType(rvIsaPkg::OpLoad, 2, 6, 5, 0));
		progA.push_back(iType(rvIsaPkg::OpLoad, 2, 7, 5, 4));
		progA.push_back(iType(rvIsaPkg::OpLoad, 2, 8, 5, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 0, 3, 7));
		progA.push_back(rType(0, 0, 9, 0, 3));
		progA.push_back(bType(0, 3, 3, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 10, 0, 1));
		progA.push_back(bType(1, 3, 3, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 10, 0, 2));
		progA.push_back(bType(4, 1, 3, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 11, 0, 3));
		progA.push_back(bType(5, 1, 3, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 11, 0, 4));
		progA.push_back(bType(6, 1, 3, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 12, 0, 5));
		progA.push_back(bType(7, 1, 3, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 12, 0, 6));
		progA.push_back(bType(4, 3, 1, 8));
		progA.push_back(bType(5, 3, 1, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 13, 0, 7));
		progA.push_back(bType(0, 3, 4, 8));
		progA.push_back(bType(6, 3, 1, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 14, 0, 8));
		progA.push_back(bType(7, 3, 1, 8));
		progA.push_back(bType(1, 3, 4, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 15, 0, 9));
		// Short countdown loop with a backward branch
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 24, 0, 3));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 24, 24, -1));
		progA.push_back(bType(1, 24, 0, -4));
		progA.push_back(jType(16, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 17, 0, 10));
		progA.push_back(uType(rvIsaPkg::OpAuipc, 18, 0));
		// Odd offset lands with bit 0 cleared
		progA.push_back(iType(rvIsaPkg::OpJalr, 0, 19, 18, 13));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 20, 0, 11));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 21, 0, 12));
		progA.push_back(jType(0, 8));
		progA.push_back(iType(rvIsaPkg::OpImm, 0, 22, 0, 13));
		progA.push_back(rType(0, 0, 23, 0, 0));
		progA.push_back(32'h0000_0000);

		progB.push_back(iType(rvIsaPkg::OpImm, 0, 1, 0, 'h200));
		progB.push_back(iType(rvIsaPkg::OpImm, 0, 2, 0, 9));
		progB.push_back(iType(rvIsaPkg::OpLoad, 2, 3, 1, 0));
		progB.push_back(iType(rvIsaPkg::OpImm, 0, 4, 0, 1));
		progB.push_back(32'h0000_0000);
	endtask

	task automatic loadProgram(input logic [31:0] words[$]);
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 32'h5A5A_0000 | 32'(i);
		end
		foreach (words[i]) begin
			mem[i] = words[i];
		end
	endtask

	task automatic runPhase(input logic [31:0] words[$], input logic holdData,
			input logic expBus, input logic [31:0] haltPc);
		rstN = 1'b0;
		holdEnable = holdData;
		loadProgram(words);
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		while (!halted) begin
			@(posedge clk);
			#1;
		end
		// Room for a stray retire to show up
		repeat (5) @(posedge clk);
		#1;
		expHalted = 1'b1;
		expBusError = expBus;
		expHaltPc = haltPc;
		statusCheck = 1'b1;
		@(posedge clk);
		#1;
		statusCheck = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// APB slave memory with random wait states
	initial begin
		apbRsp = '0;
		forever begin
			@(posedge clk);
			#1;
			if (!rstN || !apbReq.psel) begin
				apbRsp = '0;
			end else if (!apbReq.penable) begin
				waitCount = 0;
				waitTarget = $random(seed) & 3;
				apbRsp = '0;
			end else begin
				// Marked window holds data word 0x200 without pready
				if (!(holdEnable && apbReq.paddr == 32'h0000_0200) && waitCount >= waitTarget) begin
					apbRsp.pready = 1'b1;
					apbRsp.prdata = mem[apbReq.paddr[11:2]];
					if (apbReq.pwrite) mem[apbReq.paddr[11:2]] = apbReq.pwdata;
				end else begin
					apbRsp.pready = 1'b0;
				end
				waitCount++;
			end
		end
	end

	initial begin
		cycleLimit = 0;
		wait (cycleLimit > 0);
		repeat (cycleLimit) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished", cycleLimit);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		holdEnable = 1'b0;
		statusCheck = 1'b0;
		expHalted = 1'b0;
		expBusError = 1'b0;
		expHaltPc = '0;
		seed = 32'h77a9_63ea;
		buildPrograms();
		cycleLimit = (progA.size() + progB.size()) * 12 + 200;
		// Program A ends on an undecodable word
		runPhase(progA, 1'b0, 1'b0, 32'((progA.size() - 1) * 4));
		// Program B stalls on its load
		runPhase(progB, 1'b1, 1'b1, 32'h0000_0008);
		$display("Retires checked %0d, status checks %0d, errors %0d, assertion failures %0d",
			retireCount, statusCount, errorCount, uut.apbChecker.failCount);
		if (errorCount == 0 && uut.apbChecker.failCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* rvCore.f */
verilog/rvIsaPkg.sv
verilog/rvBusPkg.sv
verilog/controlDecoder.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/coreSequencer.sv
verilog/busWaitTimer.sv
verilog/rvCore.sv
dv/rvCoreApb_checker.sv
dv/rvCoreMonitor.sv
dv/rvCoreTb.sv
